//--- hw/fft_sample_pkg.sv
`default_nettype none

package fft_sample_pkg;

	// ------------------------------------------------------------------------
	// Sample widths
	// ------------------------------------------------------------------------
	parameter int SAMPLE_W = 16; // Input and output sample.
	parameter int WIDE_W = SAMPLE_W + 1; // One guard bit for a+b and a-b.

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [WIDE_W-1:0] wide_t;

	// ------------------------------------------------------------------------
	// Clamp limits
	// ------------------------------------------------------------------------
	// Largest and smallest values that fit a sample, held at the wide width
	// so the clamp compares like with like.
	parameter wide_t SAT_MAX = wide_t'((1 <<< (SAMPLE_W - 1)) - 1);
	parameter wide_t SAT_MIN = wide_t'(-(1 <<< (SAMPLE_W - 1)));

	// Sign-extends a sample to the butterfly width.
	function automatic wide_t widen(input sample_t s);
		return {s[SAMPLE_W-1], s};
	endfunction

	// Clamps a wide result to the sample range.
	function automatic sample_t clamp(input wide_t v);
		wide_t lim;
		if (v > SAT_MAX) begin
			lim = SAT_MAX;
		end else if (v < SAT_MIN) begin
			lim = SAT_MIN;
		end else begin
			lim = v;
		end
		return lim[SAMPLE_W-1:0]; // In range now, top bit is redundant.
	endfunction

endpackage

`default_nettype wire

//--- hw/bf_stage_pkg.sv
`default_nettype none

package bf_stage_pkg;

	// ------------------------------------------------------------------------
	// Stage configuration
	// ------------------------------------------------------------------------

	// Complex sample pairs handled in parallel.
	parameter int NUM_PAIRS_DEF = 16;

	// Bits needed to number a lane.
	parameter int LANE_IDX_W = (NUM_PAIRS_DEF > 1) ? $clog2(NUM_PAIRS_DEF) : 1;

	// Butterfly register, then clamp register.
	parameter int STAGE_LATENCY = 2;

	// Array elements on each side of the stage for a given pair count.
	function automatic int num_elems(input int pairs);
		return 2 * pairs;
	endfunction

endpackage

`default_nettype wire

//--- hw/bf_pair_if.sv
`timescale 1ns/1ps
`default_nettype none

interface bf_pair_if;
	import fft_sample_pkg::*;

	// Widened butterfly results of one lane.
	wide_t sum_re; // a+b, real part.
	wide_t sum_im; // a+b, imaginary part.
	wide_t diff_re; // a-b, real part.
	wide_t diff_im; // a-b, imaginary part.

	// Butterfly side.
	modport src (
		output sum_re,
		output sum_im,
		output diff_re,
		output diff_im
	);

	// Clamp side.
	modport dst (
		input sum_re,
		input sum_im,
		input diff_re,
		input diff_im
	);

endinterface

`default_nettype wire

//--- hw/bf2_lane.sv
`timescale 1ns/1ps
`default_nettype none

module bf2_lane (
	input wire logic clk,
	input wire logic rstn,
	input wire logic en,

	input wire fft_sample_pkg::sample_t a_re,
	input wire fft_sample_pkg::sample_t a_im,
	input wire fft_sample_pkg::sample_t b_re,
	input wire fft_sample_pkg::sample_t b_im,

	bf_pair_if.src bf
);
	import fft_sample_pkg::*;

	wide_t a_re_w;
	wide_t a_im_w;
	wide_t b_re_w;
	wide_t b_im_w;

	wide_t sum_re_d;
	wide_t sum_im_d;
	wide_t diff_re_d;
	wide_t diff_im_d;

	// ------------------------------------------------------------------------
	// Radix-2 butterfly
	// ------------------------------------------------------------------------
	assign a_re_w = widen(a_re);
	assign a_im_w = widen(a_im);
	assign b_re_w = widen(b_re);
	assign b_im_w = widen(b_im);

	// The guard bit covers the full 16-bit range, so no overflow here.
	assign sum_re_d = a_re_w + b_re_w;
	assign sum_im_d = a_im_w + b_im_w;
	assign diff_re_d = a_re_w - b_re_w;
	assign diff_im_d = a_im_w - b_im_w;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			bf.sum_re <= '0;
			bf.sum_im <= '0;
			bf.diff_re <= '0;
			bf.diff_im <= '0;
		end else if (en) begin
			bf.sum_re <= sum_re_d;
			bf.sum_im <= sum_im_d;
			bf.diff_re <= diff_re_d;
			bf.diff_im <= diff_im_d;
		end
	end

endmodule

`default_nettype wire

//--- hw/sat_lane.sv
`timescale 1ns/1ps
`default_nettype none

module sat_lane (
	input wire logic clk,
	input wire logic rstn,
	input wire logic en,

	bf_pair_if.dst bf,

	output fft_sample_pkg::sample_t sum_re,
	output fft_sample_pkg::sample_t sum_im,
	output fft_sample_pkg::sample_t diff_re,
	output fft_sample_pkg::sample_t diff_im
);
	import fft_sample_pkg::*;

	sample_t sum_re_c;
	sample_t sum_im_c;
	sample_t diff_re_c;
	sample_t diff_im_c;

	// ------------------------------------------------------------------------
	// Clamp to 16 bits
	// ------------------------------------------------------------------------
	// Each part saturates on its own.
	assign sum_re_c = clamp(bf.sum_re);
	assign sum_im_c = clamp(bf.sum_im);
	assign diff_re_c = clamp(bf.diff_re);
	assign diff_im_c = clamp(bf.diff_im);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sum_re <= '0;
			sum_im <= '0;
			diff_re <= '0;
			diff_im <= '0;
		end else if (en) begin
			sum_re <= sum_re_c;
			sum_im <= sum_im_c;
			diff_re <= diff_re_c;
			diff_im <= diff_im_c;
		end
	end

	// Results stay put until the next capture.

endmodule

`default_nettype wire

//--- hw/bf2_stage.sv
`timescale 1ns/1ps
`default_nettype none

module bf2_stage #(
	parameter int NUM_PAIRS = bf_stage_pkg::NUM_PAIRS_DEF
) (
	input wire logic clk,
	input wire logic rstn,
	input wire logic in_valid,

	// Element 2k is operand a of pair k, element 2k+1 is operand b.
	input wire fft_sample_pkg::sample_t in_re [bf_stage_pkg::num_elems(NUM_PAIRS)],
	input wire fft_sample_pkg::sample_t in_im [bf_stage_pkg::num_elems(NUM_PAIRS)],

	// Element 2k is the clamped a+b, element 2k+1 the clamped a-b.
	output fft_sample_pkg::sample_t out_re [bf_stage_pkg::num_elems(NUM_PAIRS)],
	output fft_sample_pkg::sample_t out_im [bf_stage_pkg::num_elems(NUM_PAIRS)],

	output logic out_valid
);
	import fft_sample_pkg::*;
	import bf_stage_pkg::*;

	// ------------------------------------------------------------------------
	// Control
	// ------------------------------------------------------------------------
	logic [STAGE_LATENCY-1:0] vld_sr; // Strobe delay line.
	logic cap_sat;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[STAGE_LATENCY-2:0], in_valid};
		end
	end

	assign cap_sat = vld_sr[0]; // Butterfly result is on the interface.
	assign out_valid = vld_sr[STAGE_LATENCY-1]; // Clamped result on the outputs.

	// ------------------------------------------------------------------------
	// Lanes
	// ------------------------------------------------------------------------
	for (genvar k = 0; k < NUM_PAIRS; k++) begin : g_lane
		bf_pair_if bf ();

		bf2_lane u_bf (
			.clk (clk),
			.rstn (rstn),
			.en (in_valid),
			.a_re (in_re[2*k]),
			.a_im (in_im[2*k]),
			.b_re (in_re[2*k+1]),
			.b_im (in_im[2*k+1]),
			.bf (bf.src)
		);

		sat_lane u_sat (
			.clk (clk),
			.rstn (rstn),
			.en (cap_sat),
			.bf (bf.dst),
			.sum_re (out_re[2*k]),
			.sum_im (out_im[2*k]),
			.diff_re (out_re[2*k+1]),
			.diff_im (out_im[2*k+1])
		);
	end

endmodule

`default_nettype wire

//--- include/bf2_ref_model.svh
`ifndef BF2_REF_MODEL_SVH
`define BF2_REF_MODEL_SVH

// Saturates an integer result to the signed sample range.
function automatic fft_sample_pkg::sample_t clamp16(input int v);
	int lim;
	if (v > int'(fft_sample_pkg::SAT_MAX)) begin
		lim = int'(fft_sample_pkg::SAT_MAX);
	end else if (v < int'(fft_sample_pkg::SAT_MIN)) begin
		lim = int'(fft_sample_pkg::SAT_MIN);
	end else begin
		lim = v;
	end
	return fft_sample_pkg::sample_t'(lim);
endfunction

// Expected even output element, a+b clamped.
function automatic fft_sample_pkg::sample_t exp_sum(
	input fft_sample_pkg::sample_t a,
	input fft_sample_pkg::sample_t b
);
	return clamp16(int'(a) + int'(b));
endfunction

// Expected odd output element, a-b clamped.
function automatic fft_sample_pkg::sample_t exp_diff(
	input fft_sample_pkg::sample_t a,
	input fft_sample_pkg::sample_t b
);
	return clamp16(int'(a) - int'(b));
endfunction

`endif

//--- test/tb_bf2_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bf2_stage;
	import fft_sample_pkg::*;
	import bf_stage_pkg::*;

	`include "bf2_ref_model.svh"

	localparam int NP = NUM_PAIRS_DEF;
	localparam int NE = 2 * NP; // Array elements per side.

	logic clk;
	logic rstn;
	logic in_valid;
	sample_t in_re [NE];
	sample_t in_im [NE];
	sample_t out_re [NE];
	sample_t out_im [NE];
	logic out_valid;

	// ------------------------------------------------------------------------
	// Scoreboard state
	// ------------------------------------------------------------------------
	int edge_cnt; // Rising edges since reset release.
	int due_q [$]; // Edge after which out_valid must be high.
	int exp_q [$]; // Expected outputs, re then im, per strobe.
	int last_re [NE];
	int last_im [NE];

	string test_name;
	int data_errs;
	int ctrl_errs;
	int timeouts;

	bf2_stage dut0 (
		.clk (clk),
		.rstn (rstn),
		.in_valid (in_valid),
		.in_re (in_re),
		.in_im (in_im),
		.out_re (out_re),
		.out_im (out_im),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	task automatic check_value(input string what, input int idx, input int exp_v,
			input int act_v);
		assert (act_v == exp_v) else begin
			data_errs++;
			$display("Error [%s] %s[%0d]: expected %0d, actual %0d",
				test_name, what, idx, exp_v, act_v);
		end
	endtask

	// Queues the expected result of a strobe seen at this rising edge.
	task automatic record_strobe();
		int k;
		edge_cnt++;
		if (in_valid) begin
			due_q.push_back(edge_cnt + STAGE_LATENCY - 1);
			for (k = 0; k < NP; k++) begin
				exp_q.push_back(int'(exp_sum(in_re[2*k], in_re[2*k+1])));
				exp_q.push_back(int'(exp_diff(in_re[2*k], in_re[2*k+1])));
			end
			for (k = 0; k < NP; k++) begin
				exp_q.push_back(int'(exp_sum(in_im[2*k], in_im[2*k+1])));
				exp_q.push_back(int'(exp_diff(in_im[2*k], in_im[2*k+1])));
			end
		end
	endtask

	// Outputs are settled at the falling edge.
	task automatic check_outputs();
		bit due;
		int i;
		due = (due_q.size() > 0) && (due_q[0] == edge_cnt);
		assert (out_valid == due) else begin
			ctrl_errs++;
			$display("Error [%s] out_valid after edge %0d: expected %0d, actual %0d",
				test_name, edge_cnt, due, out_valid);
		end
		if (due && out_valid) begin
			void'(due_q.pop_front());
			for (i = 0; i < NE; i++) begin
				last_re[i] = exp_q.pop_front();
			end
			for (i = 0; i < NE; i++) begin
				last_im[i] = exp_q.pop_front();
			end
		end
		// Without a strobe the last result must hold.
		for (i = 0; i < NE; i++) begin
			check_value("out_re", i, last_re[i], int'(out_re[i]));
			check_value("out_im", i, last_im[i], int'(out_im[i]));
		end
	endtask

	always @(posedge clk) begin
		if (rstn) begin
			record_strobe();
		end
	end

	always @(negedge clk) begin
		if (rstn) begin
			check_outputs();
		end
	end

	task automatic check_reset_state();
		int i;
		assert (out_valid == 1'b0) else begin
			ctrl_errs++;
			$display("Error [%s] out_valid: expected 0, actual %0d", test_name, out_valid);
		end
		for (i = 0; i < NE; i++) begin
			check_value("out_re", i, 0, int'(out_re[i]));
			check_value("out_im", i, 0, int'(out_im[i]));
		end
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	function automatic sample_t rand_sample(input bit full);
		if (full) begin
			return sample_t'($urandom);
		end
		return sample_t'(int'($urandom % 32768) - 16384); // Sum and difference fit.
	endfunction

	task automatic load_random(input bit full);
		int i;
		for (i = 0; i < NE; i++) begin
			in_re[i] = rand_sample(full);
			in_im[i] = rand_sample(full);
		end
	endtask

	task automatic set_pair(input int k, input int ar, input int br, input int ai,
			input int bi);
		in_re[2*k] = sample_t'(ar);
		in_re[2*k+1] = sample_t'(br);
		in_im[2*k] = sample_t'(ai);
		in_im[2*k+1] = sample_t'(bi);
	endtask

	// Overflow in either direction, next to values that stay in range.
	task automatic load_saturation();
		int k;
		for (k = 0; k < NP; k++) begin
			case (k % 4)
				0: set_pair(k, 30000, 30000, -30000, 30000);
				1: set_pair(k, -32768, -32768, 32767, -32768);
				2: set_pair(k, 30000, -30000, -30000, -30000);
				default: set_pair(k, 16384, 16383, -16384, 16384); // Exactly at the limits.
			endcase
		end
	endtask

	task automatic pulse_strobe();
		in_valid = 1'b1;
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (due_q.size() != 0 && n < limit) begin
			@(posedge clk);
			n++;
		end
		if (due_q.size() != 0) begin
			timeouts++;
			$display("Timeout in test %s: out_valid never came for %0d pending strobes",
				test_name, due_q.size());
			due_q.delete();
			exp_q.delete();
		end
		@(negedge clk);
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		void'($urandom(41));
		rstn = 1'b0;
		in_valid = 1'b0;
		for (int i = 0; i < NE; i++) begin
			in_re[i] = '0;
			in_im[i] = '0;
			last_re[i] = 0;
			last_im[i] = 0;
		end
		edge_cnt = 0;
		data_errs = 0;
		ctrl_errs = 0;
		timeouts = 0;
		test_name = "reset";

		repeat (4) @(negedge clk);
		rstn = 1'b1;
		repeat (3) @(negedge clk);
		check_reset_state();

		test_name = "arith";
		for (int n = 0; n < 8; n++) begin
			load_random(1'b0);
			pulse_strobe();
			wait_idle(10);
		end

		test_name = "saturation";
		load_saturation();
		pulse_strobe();
		wait_idle(10);
		check_value("sat out_re", 0, 32767, int'(out_re[0]));
		check_value("sat out_re", 1, 0, int'(out_re[1]));
		check_value("sat out_im", 1, -32768, int'(out_im[1]));
		check_value("sat out_re", 2, -32768, int'(out_re[2]));

		test_name = "burst";
		in_valid = 1'b1;
		for (int n = 0; n < 6; n++) begin
			load_random(1'b1);
			@(negedge clk);
		end
		in_valid = 1'b0;
		wait_idle(20);

		// Inputs move, in_valid stays low.
		test_name = "hold";
		for (int n = 0; n < 5; n++) begin
			load_random(1'b1);
			@(negedge clk);
		end
		wait_idle(10);

		$display("Errors: %0d data, %0d control, %0d timeouts",
			data_errs, ctrl_errs, timeouts);
		if (data_errs + ctrl_errs + timeouts == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+include
hw/fft_sample_pkg.sv
hw/bf_stage_pkg.sv
hw/bf_pair_if.sv
hw/bf2_lane.sv
hw/sat_lane.sv
hw/bf2_stage.sv
test/tb_bf2_stage.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
	--top-module tb_bf2_stage \
	-f list.f \
	-o sim_tb_bf2_stage

./obj_dir/sim_tb_bf2_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
	echo "Simulation reported failure, see sim.log"
	exit 1
fi

echo "Simulation finished without failure"
exit 0
